// ==== src/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

    // architectural sizes
    localparam int DataWidth = 32;
    localparam int RegCount = 32;

    // instruction field widths
    localparam int OpcodeWidth = 6;
    localparam int RegIdxWidth = 5;
    localparam int ShamtWidth = 5;
    localparam int FunctWidth = 6;
    localparam int ImmWidth = 16;

    typedef logic [DataWidth-1:0] word_t;
    typedef logic [RegIdxWidth-1:0] regIdx_t;

    typedef enum logic [OpcodeWidth-1:0] {
        OpSpecial = 6'h00,
        OpAddiu   = 6'h09,
        OpSlti    = 6'h0a,
        OpSltiu   = 6'h0b,
        OpAndi    = 6'h0c,
        OpOri     = 6'h0d,
        OpXori    = 6'h0e,
        OpLui     = 6'h0f
    } opcode_e;

    // special-function codes under opcode 0
    typedef enum logic [FunctWidth-1:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnSra  = 6'h03,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnNor  = 6'h27,
        FnSlt  = 6'h2a,
        FnSltu = 6'h2b
    } funct_e;

endpackage

`default_nettype wire

// ==== src/pipePkg.sv ====
`default_nettype none

package pipePkg;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluSra
    } aluOp_e;

    // decode register
    typedef struct packed {
        logic                                  valid;
        aluOp_e                                aluOp;
        mipsIsaPkg::regIdx_t                   srcA;
        mipsIsaPkg::regIdx_t                   srcB;
        mipsIsaPkg::regIdx_t                   dest;
        mipsIsaPkg::word_t                     opA;
        mipsIsaPkg::word_t                     opB;
        mipsIsaPkg::word_t                     imm;
        logic [mipsIsaPkg::ShamtWidth-1:0]     shamt;
        logic                                  useImm;
    } decoded_t;

    // execute and result registers
    typedef struct packed {
        logic                valid;
        mipsIsaPkg::regIdx_t dest;
        mipsIsaPkg::word_t   result;
    } execResult_t;

    typedef struct packed {
        mipsIsaPkg::regIdx_t dest;
        mipsIsaPkg::word_t   value;
    } resultBeat_t;

    typedef struct packed {
        logic                en;
        mipsIsaPkg::regIdx_t idx;
        mipsIsaPkg::word_t   data;
    } regWrite_t;

endpackage

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                       clk_i,
    input  wire                       arstN_i,
    input  wire mipsIsaPkg::regIdx_t  raddrA_i,
    input  wire mipsIsaPkg::regIdx_t  raddrB_i,
    output mipsIsaPkg::word_t         rdataA_o,
    output mipsIsaPkg::word_t         rdataB_o,
    input  wire pipePkg::regWrite_t   write_i
);

    mipsIsaPkg::word_t regs [mipsIsaPkg::RegCount];

    // write-through with r0 reading zero
    function automatic mipsIsaPkg::word_t readPort(
        input mipsIsaPkg::regIdx_t idx,
        input mipsIsaPkg::word_t   stored,
        input pipePkg::regWrite_t  wr
    );
        if (idx == '0) begin
            return '0;
        end
        if (wr.en && wr.idx == idx) begin
            return wr.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < mipsIsaPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (write_i.en && write_i.idx != '0) begin
            regs[write_i.idx] <= write_i.data;
        end
    end

    assign rdataA_o = readPort(raddrA_i, regs[raddrA_i], write_i);
    assign rdataB_o = readPort(raddrB_i, regs[raddrB_i], write_i);

endmodule

`default_nettype wire

// ==== src/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  wire                       clk_i,
    input  wire                       arstN_i,
    input  wire                       advance_i,
    input  wire                       instrValid_i,
    input  wire mipsIsaPkg::word_t    instrWord_i,
    input  wire mipsIsaPkg::word_t    rdataA_i,
    input  wire mipsIsaPkg::word_t    rdataB_i,
    output mipsIsaPkg::regIdx_t       raddrA_o,
    output mipsIsaPkg::regIdx_t       raddrB_o,
    output pipePkg::decoded_t         decoded_o
);

    mipsIsaPkg::opcode_e                 opcode;
    mipsIsaPkg::funct_e                  funct;
    mipsIsaPkg::regIdx_t                 rs;
    mipsIsaPkg::regIdx_t                 rt;
    mipsIsaPkg::regIdx_t                 rd;
    logic [mipsIsaPkg::ShamtWidth-1:0]   shamt;
    logic [mipsIsaPkg::ImmWidth-1:0]     imm16;
    pipePkg::decoded_t                   decodeD;

    assign opcode = mipsIsaPkg::opcode_e'(instrWord_i[31:26]);
    assign rs     = instrWord_i[25:21];
    assign rt     = instrWord_i[20:16];
    assign rd     = instrWord_i[15:11];
    assign shamt  = instrWord_i[10:6];
    assign funct  = mipsIsaPkg::funct_e'(instrWord_i[5:0]);
    assign imm16  = instrWord_i[15:0];

    assign raddrA_o = rs;
    assign raddrB_o = rt;

    always_comb begin
        decodeD        = '0;
        decodeD.valid  = instrValid_i;
        decodeD.srcA   = rs;
        decodeD.srcB   = rt;
        decodeD.opA    = rdataA_i;
        decodeD.opB    = rdataB_i;
        decodeD.shamt  = shamt;
        decodeD.imm    = {{(mipsIsaPkg::DataWidth - mipsIsaPkg::ImmWidth){imm16[15]}}, imm16};
        decodeD.useImm = 1'b1;
        decodeD.dest   = rt;
        decodeD.aluOp  = pipePkg::AluAdd;
        case (opcode)
            mipsIsaPkg::OpSpecial: begin
                decodeD.useImm = 1'b0;
                decodeD.dest   = rd;
                case (funct)
                    mipsIsaPkg::FnSll:  decodeD.aluOp = pipePkg::AluSll;
                    mipsIsaPkg::FnSrl:  decodeD.aluOp = pipePkg::AluSrl;
                    mipsIsaPkg::FnSra:  decodeD.aluOp = pipePkg::AluSra;
                    mipsIsaPkg::FnAddu: decodeD.aluOp = pipePkg::AluAdd;
                    mipsIsaPkg::FnSubu: decodeD.aluOp = pipePkg::AluSub;
                    mipsIsaPkg::FnAnd:  decodeD.aluOp = pipePkg::AluAnd;
                    mipsIsaPkg::FnOr:   decodeD.aluOp = pipePkg::AluOr;
                    mipsIsaPkg::FnXor:  decodeD.aluOp = pipePkg::AluXor;
                    mipsIsaPkg::FnNor:  decodeD.aluOp = pipePkg::AluNor;
                    mipsIsaPkg::FnSlt:  decodeD.aluOp = pipePkg::AluSlt;
                    mipsIsaPkg::FnSltu: decodeD.aluOp = pipePkg::AluSltu;
                    default:            decodeD.dest  = '0;
                endcase
            end
            mipsIsaPkg::OpAddiu: decodeD.aluOp = pipePkg::AluAdd;
            mipsIsaPkg::OpSlti:  decodeD.aluOp = pipePkg::AluSlt;
            mipsIsaPkg::OpSltiu: decodeD.aluOp = pipePkg::AluSltu;
            // logical immediates are zero-extended
            mipsIsaPkg::OpAndi: begin
                decodeD.aluOp = pipePkg::AluAnd;
                decodeD.imm   = mipsIsaPkg::word_t'(imm16);
            end
            mipsIsaPkg::OpOri: begin
                decodeD.aluOp = pipePkg::AluOr;
                decodeD.imm   = mipsIsaPkg::word_t'(imm16);
            end
            mipsIsaPkg::OpXori: begin
                decodeD.aluOp = pipePkg::AluXor;
                decodeD.imm   = mipsIsaPkg::word_t'(imm16);
            end
            // lui is the immediate shifted left by 16
            mipsIsaPkg::OpLui: begin
                decodeD.aluOp = pipePkg::AluSll;
                decodeD.shamt = 5'd16;
            end
            default: decodeD.dest = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            decoded_o <= '0;
        end else if (advance_i) begin
            decoded_o <= decodeD;
        end
    end

endmodule

`default_nettype wire

// ==== src/aluExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
    input  wire                        clk_i,
    input  wire                        arstN_i,
    input  wire                        advance_i,
    input  wire pipePkg::decoded_t     decoded_i,
    input  wire pipePkg::execResult_t  resultFwd_i,
    output pipePkg::execResult_t       exec_o
);

    mipsIsaPkg::word_t    opA;
    mipsIsaPkg::word_t    fwdB;
    mipsIsaPkg::word_t    opB;
    mipsIsaPkg::word_t    aluOut;
    pipePkg::execResult_t execD;

    // newest producer wins and r0 is never forwarded
    function automatic mipsIsaPkg::word_t resolveOperand(
        input mipsIsaPkg::regIdx_t  idx,
        input mipsIsaPkg::word_t    captured,
        input pipePkg::execResult_t execQ,
        input pipePkg::execResult_t resultQ
    );
        if (idx == '0) begin
            return '0;
        end
        if (execQ.valid && execQ.dest == idx) begin
            return execQ.result;
        end
        if (resultQ.valid && resultQ.dest == idx) begin
            return resultQ.result;
        end
        return captured;
    endfunction

    assign opA  = resolveOperand(decoded_i.srcA, decoded_i.opA, exec_o, resultFwd_i);
    assign fwdB = resolveOperand(decoded_i.srcB, decoded_i.opB, exec_o, resultFwd_i);
    assign opB  = decoded_i.useImm ? decoded_i.imm : fwdB;

    always_comb begin
        case (decoded_i.aluOp)
            pipePkg::AluAdd:  aluOut = opA + opB;
            pipePkg::AluSub:  aluOut = opA - opB;
            pipePkg::AluAnd:  aluOut = opA & opB;
            pipePkg::AluOr:   aluOut = opA | opB;
            pipePkg::AluXor:  aluOut = opA ^ opB;
            pipePkg::AluNor:  aluOut = ~(opA | opB);
            pipePkg::AluSlt:  aluOut = mipsIsaPkg::word_t'($signed(opA) < $signed(opB));
            pipePkg::AluSltu: aluOut = mipsIsaPkg::word_t'(opA < opB);
            // shifts act on operand B like rt in MIPS
            pipePkg::AluSll:  aluOut = opB << decoded_i.shamt;
            pipePkg::AluSrl:  aluOut = opB >> decoded_i.shamt;
            pipePkg::AluSra:  aluOut = $signed(opB) >>> decoded_i.shamt;
            default:          aluOut = '0;
        endcase
    end

    always_comb begin
        execD.valid  = decoded_i.valid;
        execD.dest   = decoded_i.dest;
        execD.result = aluOut;
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            exec_o <= '0;
        end else if (advance_i) begin
            exec_o <= execD;
        end
    end

endmodule

`default_nettype wire

// ==== src/writeResult.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeResult (
    input  wire                        clk_i,
    input  wire                        arstN_i,
    input  wire pipePkg::execResult_t  exec_i,
    input  wire                        resultReady_i,
    output logic                       advance_o,
    output pipePkg::regWrite_t         regWrite_o,
    output pipePkg::execResult_t       resultFwd_o,
    output logic                       resultValid_o,
    output pipePkg::resultBeat_t       result_o
);

    pipePkg::execResult_t resultQ;

    // whole pipe moves only when the output slot frees up
    assign advance_o = !resultQ.valid || resultReady_i;

    // register file is written on the edge that loads the result register
    always_comb begin
        regWrite_o.en   = exec_i.valid && advance_o;
        regWrite_o.idx  = exec_i.dest;
        regWrite_o.data = exec_i.result;
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            resultQ <= '0;
        end else if (advance_o) begin
            resultQ <= exec_i;
        end
    end

    assign resultFwd_o    = resultQ;
    assign resultValid_o  = resultQ.valid;
    assign result_o.dest  = resultQ.dest;
    assign result_o.value = resultQ.result;

endmodule

`default_nettype wire

// ==== src/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  wire                       clk_i,
    input  wire                       arstN_i,
    input  wire                       instrValid_i,
    input  wire mipsIsaPkg::word_t    instrWord_i,
    output logic                      instrReady_o,
    output logic                      resultValid_o,
    output pipePkg::resultBeat_t      result_o,
    input  wire                       resultReady_i
);

    logic                  advance;
    mipsIsaPkg::regIdx_t   raddrA;
    mipsIsaPkg::regIdx_t   raddrB;
    mipsIsaPkg::word_t     rdataA;
    mipsIsaPkg::word_t     rdataB;
    pipePkg::decoded_t     decoded;
    pipePkg::execResult_t  exec;
    pipePkg::execResult_t  resultFwd;
    pipePkg::regWrite_t    regWrite;

    assign instrReady_o = advance;

    regFile regFileInst (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .raddrA_i (raddrA),
        .raddrB_i (raddrB),
        .rdataA_o (rdataA),
        .rdataB_o (rdataB),
        .write_i  (regWrite)
    );

    instrDecode instrDecodeInst (
        .clk_i        (clk_i),
        .arstN_i      (arstN_i),
        .advance_i    (advance),
        .instrValid_i (instrValid_i),
        .instrWord_i  (instrWord_i),
        .rdataA_i     (rdataA),
        .rdataB_i     (rdataB),
        .raddrA_o     (raddrA),
        .raddrB_o     (raddrB),
        .decoded_o    (decoded)
    );

    aluExecute aluExecuteInst (
        .clk_i       (clk_i),
        .arstN_i     (arstN_i),
        .advance_i   (advance),
        .decoded_i   (decoded),
        .resultFwd_i (resultFwd),
        .exec_o      (exec)
    );

    writeResult writeResultInst (
        .clk_i         (clk_i),
        .arstN_i       (arstN_i),
        .exec_i        (exec),
        .resultReady_i (resultReady_i),
        .advance_o     (advance),
        .regWrite_o    (regWrite),
        .resultFwd_o   (resultFwd),
        .resultValid_o (resultValid_o),
        .result_o      (result_o)
    );

endmodule

`default_nettype wire

// ==== tests/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk_o,
    output logic arstN_o
);

    localparam int HalfPeriod = 50;
    localparam int ResetCycles = 4;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HalfPeriod);
            clk_o = ~clk_o;
        end
    end

    // release just after an edge
    initial begin
        arstN_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        #1;
        arstN_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/mipsCore_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore_props (
    input wire                       clk_i,
    input wire                       arstN_i,
    input wire                       instrReady_i,
    input wire                       resultValid_i,
    input wire                       resultReady_i,
    input wire pipePkg::resultBeat_t result_i
);

    // a stalled beat stays put until it is taken
    resultHeld: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        resultValid_i && !resultReady_i |=> resultValid_i && $stable(result_i)
    ) else $error("result_o changed or dropped while resultReady_i was low");

    // pipe stalls only behind a full output slot
    readyLowOnlyWhenFull: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        !instrReady_i |-> resultValid_i
    ) else $error("instrReady_o low with no result waiting");

    validKnown: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        !$isunknown(resultValid_i)
    ) else $error("resultValid_o is unknown after reset");

endmodule

bind mipsCore mipsCore_props props (
    .clk_i         (clk_i),
    .arstN_i       (arstN_i),
    .instrReady_i  (instrReady_o),
    .resultValid_i (resultValid_o),
    .resultReady_i (resultReady_i),
    .result_i      (result_o)
);

`default_nettype wire

// ==== tests/mipsCore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore_tb;

    localparam int StimCount = 32;
    localparam int Passes = 2;
    localparam int TotalBeats = StimCount * Passes;
    localparam int CycleLimit = 30 * TotalBeats + 50;
    // beat counts that close a group of stim entries
    localparam int IsaGroupEnd = 19;
    localparam int FwdGroupEnd = 28;

    logic                 clk;
    logic                 arstN;
    logic                 instrValid;
    mipsIsaPkg::word_t    instrWord;
    logic                 instrReady;
    logic                 resultValid;
    pipePkg::resultBeat_t result;
    logic                 resultReady;

    // word, dest, value per entry
    logic [31:0] stimMem [3 * StimCount];
    int          checkCount = 0;
    int          passCount = 0;
    int          errorCount = 0;
    int          groupChecks = 0;
    int          groupErrors = 0;
    int          beatCount = 0;
    int          cycleCount = 0;
    int unsigned lcgState = 60048;
    logic        randomMode = 1'b0;

    clockGen clockGenInst (
        .clk_o   (clk),
        .arstN_o (arstN)
    );

    mipsCore uut (
        .clk_i         (clk),
        .arstN_i       (arstN),
        .instrValid_i  (instrValid),
        .instrWord_i   (instrWord),
        .instrReady_o  (instrReady),
        .resultValid_o (resultValid),
        .result_o      (result),
        .resultReady_i (resultReady)
    );

    function automatic int unsigned nextRand();
        lcgState = lcgState * 1103515245 + 12345;
        return lcgState >> 16;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end else begin
            passCount++;
        end
    endtask

    task automatic reportGroup(input string name);
        $display("test %s: %0d checks, %0d errors", name, checkCount - groupChecks,
                 errorCount - groupErrors);
        groupChecks = checkCount;
        groupErrors = errorCount;
    endtask

    // inputs change 1 ns after the edge
    task automatic waitEdge();
        @(posedge clk);
        #1;
        // ready drops about one cycle in three when stalls are on
        resultReady = randomMode ? (nextRand() % 3 != 0) : 1'b1;
    endtask

    task automatic sendInstr(input mipsIsaPkg::word_t word);
        logic accepted;
        accepted = 1'b0;
        while (randomMode && nextRand() % 4 == 0) begin
            waitEdge();
        end
        instrValid = 1'b1;
        instrWord  = word;
        while (!accepted) begin
            @(negedge clk);
            accepted = instrReady;
            waitEdge();
        end
        instrValid = 1'b0;
    endtask

    task automatic takeBeat();
        int entry;
        entry = beatCount % StimCount;
        if (beatCount >= TotalBeats) begin
            errorCount++;
            $display("unexpected extra result beat at %0t for register %0d", $time, result.dest);
        end else begin
            checkValue($sformatf("dest of entry %0d", entry), 32'(result.dest),
                       stimMem[3 * entry + 1]);
            checkValue($sformatf("value of entry %0d", entry), result.value,
                       stimMem[3 * entry + 2]);
            beatCount++;
            if (beatCount == IsaGroupEnd) begin
                reportGroup("instruction set");
            end else if (beatCount == FwdGroupEnd) begin
                reportGroup("forwarding");
            end else if (beatCount == StimCount) begin
                reportGroup("register zero");
            end else if (beatCount == TotalBeats) begin
                reportGroup("stalls and gaps");
            end
        end
    endtask

    // a beat seen mid-cycle transfers at the next edge
    always @(negedge clk) begin
        if (arstN === 1'b1 && resultValid === 1'b1 && resultReady === 1'b1) begin
            takeBeat();
        end
    end

    initial begin
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, %0d of %0d result beats received",
                 cycleCount, beatCount, TotalBeats);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        instrValid  = 1'b0;
        instrWord   = '0;
        resultReady = 1'b1;
        $readmemh("tests/mipsCore_stim.txt", stimMem);
        wait (arstN === 1'b1);
        @(negedge clk);
        checkValue("resultValid_o after reset", 32'(resultValid), 32'd0);
        checkValue("instrReady_o after reset", 32'(instrReady), 32'd1);
        reportGroup("reset");
        waitEdge();
        for (int p = 0; p < Passes; p++) begin
            // second pass replays the program with random stalls and gaps
            randomMode = (p == 1);
            for (int i = 0; i < StimCount; i++) begin
                sendInstr(stimMem[3 * i]);
            end
        end
        while (beatCount < TotalBeats) begin
            waitEdge();
        end
        randomMode = 1'b0;
        repeat (4) begin
            waitEdge();
        end
        $display("passed %0d, errors %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mipsCore.f ====
src/mipsIsaPkg.sv
src/pipePkg.sv
src/regFile.sv
src/instrDecode.sv
src/aluExecute.sv
src/writeResult.sv
src/mipsCore.sv
tests/clockGen.sv
tests/mipsCore_props.sv
tests/mipsCore_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = mipsCore_tb
FILELIST  = mipsCore.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/mipsCore_stim.txt ====
// columns: instruction word, expected destination register, expected value written (all hex)
// every register is written before it is read, so the program can be replayed
// instruction set
3c018000 01 80000000
34210001 01 80000001
3c027fff 02 7fff0000
3442ffff 02 7fffffff
2403ffff 03 ffffffff
00212021 04 00000002
00022823 05 80000001
00413024 06 00000001
00223825 07 ffffffff
00234026 08 7ffffffe
00404827 09 80000000
0022502a 0a 00000001
0022582b 0b 00000000
00016100 0c 00000010
00016902 0d 08000000
00017103 0e f8000000
286f8000 0f 00000000
30708001 10 00008001
38718000 11 ffff7fff
// forwarding at distance 1, 2 and 3, newest producer wins
24140011 14 00000011
0294a821 15 00000022
02b4b023 16 00000011
0295b825 17 00000033
02f6c026 18 00000022
0018c840 19 00000044
241b0001 1b 00000001
277b0001 1b 00000002
0360e021 1c 00000002
// register zero
24000005 00 00000005
0000e821 1d 00000000
341e0007 1e 00000007
001ef821 1f 00000007
